// ==== Bender.yml ====
package:
  name: fe_loader

sources:
  - include_dirs:
      - source
    files:
      - source/feLoaderPkg.sv
      - source/loadCmdRegs.sv
      - source/loadSequencer.sv
      - source/diagDataMux.sv
      - source/ebusCycle.sv
      - source/feLoaderTop.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/feLoaderTb.sv

// ==== dv/feLoaderTb.sv ====
// Front-end loader testbench
`include "feLoader_config.svh"

module feLoaderTbTop;
  timeunit 1ns;
  timeprecision 100ps;
  import feLoaderPkg::*;

  // Traffic is about 1800 cycles, master resets dominate
  localparam int MaxCycles = 4000;
  localparam int WrStrobe  = `FE_WRITE_STROBE_CYC;
  localparam int WrDrive   = `FE_WRITE_DRIVE_CYC;
  localparam int FnStrobe  = `FE_FUNC_STROBE_CYC;

  // One observed or expected diagnostic bus cycle
  typedef struct packed {
    logic [6:0]            ds;
    logic [`FE_EBUS_W-1:0] data;
    logic [7:0]            strobeLen;
    logic [7:0]            driveLen;
  } busEntry_t;

  logic      clk;
  logic      rstN;
  logic      cmdStart;
  loadCmd_t  cmd;
  logic      aChangeComingN;
  ebusDiag_t ebus;
  logic      busy;
  logic      done;
  logic      syncError;

  integer          seed;
  int              cycleCount    = 0;
  int              stepClockSeen = 0;
  int              stepBase      = 0;
  busEntry_t       seenQ[$];
  busEntry_t       expQ[$];
  busEntry_t       curEntry;
  logic            inEntry       = 1'b0;
  // Model copies of the running addresses
  logic [10:0]     cramRun;
  logic [8:0]      dramRun;

  feLoaderTop u_dut (
    .clk            (clk),
    .rstN           (rstN),
    .cmdStart       (cmdStart),
    .cmd            (cmd),
    .aChangeComingN (aChangeComingN),
    .ebus           (ebus),
    .busy           (busy),
    .done           (done),
    .syncError      (syncError)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic failRun(input string msg);
    $display("Verification failed");
    $display("%s", msg);
    $fatal(1);
  endtask

  task automatic expectHex(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (exp == got)
      else failRun($sformatf("Error: %s expected 0x%0h got 0x%0h", name, exp, got));
  endtask

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= MaxCycles) begin
      failRun($sformatf("Timeout: the run did not finish within %0d cycles", MaxCycles));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus monitor, one entry per strobe, closed when strobe and drive drop
  always @(posedge clk) begin
    if (inEntry) begin
      if (ebus.diagStrobe) curEntry.strobeLen++;
      if (ebus.driving) curEntry.driveLen++;
      if (!ebus.diagStrobe && !ebus.driving) begin
        seenQ.push_back(curEntry);
        inEntry = 1'b0;
      end
    end else if (ebus.diagStrobe) begin
      curEntry.ds        = ebus.ds;
      curEntry.data      = ebus.data;
      curEntry.strobeLen = 8'd1;
      curEntry.driveLen  = 8'(ebus.driving);
      inEntry            = 1'b1;
      if (ebus.ds == STEP_CLOCK) stepClockSeen++;
    end
  end

  // No EBUS activity outside a command
  assert property (@(posedge clk) disable iff (!rstN)
                   !busy |-> !ebus.diagStrobe && !ebus.driving)
    else failRun("EBUS strobe or drive seen while the loader was idle");
  assert property (@(posedge clk) disable iff (!rstN) done |-> busy)
    else failRun("Done pulsed while the loader was not busy");
  assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
    else failRun("Done was high for more than one cycle");
  // Drive must end before the next strobe starts
  assert property (@(posedge clk) disable iff (!rstN)
                   $rose(ebus.diagStrobe) |-> !$past(ebus.driving))
    else failRun("Strobe started while data was still driven");
  assert property (@(posedge clk) disable iff (!rstN) !busy |-> $stable(syncError))
    else failRun("Sync error changed while the loader was idle");

  ////////////////////////////////////////////////////////////////////////////
  // Reference model

  // Place value MSB first at KL bit klFirst
  function automatic logic [35:0] putKl(int klFirst, int width, logic [35:0] value);
    logic [35:0] w;
    w = '0;
    for (int i = 0; i < width; i++) begin
      w[35 - klFirst - i] = value[width - 1 - i];
    end
    return w;
  endfunction

  // Twenty control bits into KL groups 8-11, 14-17, 20-23, 26-29, 32-35
  function automatic logic [35:0] cramSlice(logic [85:0] cw, int first);
    logic [35:0] w;
    w = '0;
    for (int j = 0; j < 20; j++) begin
      w[35 - (8 + 6 * (j / 4) + j % 4)] = cw[85 - first - j];
    end
    return w;
  endfunction

  function automatic logic [35:0] cramTop(logic [85:0] cw);
    logic [35:0] w;
    w = '0;
    for (int i = 0; i < 6; i++) begin
      w[35 - i] = cw[85 - (80 + i)];
    end
    return w;
  endfunction

  function automatic void addStep(diagFunc_e f, logic isWr, logic [35:0] d);
    busEntry_t e;
    e.ds        = f;
    e.data      = isWr ? d : '0;
    e.strobeLen = isWr ? 8'(WrStrobe) : 8'(FnStrobe);
    e.driveLen  = isWr ? 8'(WrDrive) : 8'd0;
    expQ.push_back(e);
  endfunction

  function automatic void buildCram(loadCmd_t c);
    logic [10:0] adr;
    adr     = (c.adr == '0) ? cramRun : c.adr;
    cramRun = adr + 11'd1;
    addStep(CRAM_DIAG_ADR_RH, 1'b1, putKl(0, 6, 36'(adr[5:0])));
    addStep(CRAM_DIAG_ADR_LH, 1'b1, putKl(1, 5, 36'(adr[10:6])));
    addStep(CRAM_WRITE_60_79, 1'b1, cramSlice(c.cw, 60));
    addStep(CRAM_WRITE_40_59, 1'b1, cramSlice(c.cw, 40));
    addStep(CRAM_WRITE_20_39, 1'b1, cramSlice(c.cw, 20));
    addStep(CRAM_WRITE_00_19, 1'b1, cramSlice(c.cw, 0));
    addStep(CRAM_WRITE_80_85, 1'b1, cramTop(c.cw));
  endfunction

  function automatic void buildDram(loadCmd_t c);
    int a;
    int ir;
    a       = (c.adr[8:0] == '0) ? int'(dramRun) : int'(c.adr[8:0]);
    dramRun = 9'(a + 2);
    // 7xx opcodes spread over IR, others take four trailing zeros
    if (a / 64 != 7) begin
      ir = a * 16;
    end else begin
      ir = (7 << 10) | (((a / 8) % 8) << 3) | (a % 8);
    end
    addStep(LOAD_AR, 1'b1, putKl(0, 13, 36'(ir)));
    addStep(IRLTCH, 1'b0, '0);
    addStep(LDRAM1, 1'b1, 36'(c.dram.even) << 18);
    addStep(LDRAM2, 1'b1, 36'(c.dram.odd) << 18);
    addStep(LDRAM3, 1'b1, 36'(c.dram.common) << 18);
    addStep(LDRJEV, 1'b1, 36'(c.dram.even) << 18);
    addStep(LDRJOD, 1'b1, 36'(c.dram.odd) << 18);
  endfunction

  function automatic void buildSoftReset();
    addStep(SET_RESET, 1'b0, '0);
    addStep(START_CLOCK, 1'b0, '0);
    addStep(STOP_CLOCK, 1'b0, '0);
    addStep(COND_STEP, 1'b0, '0);
    addStep(CLR_RESET, 1'b0, '0);
  endfunction

  function automatic void buildMasterReset(int steps);
    addStep(CLR_RUN, 1'b0, '0);
    // Phase one
    addStep(CLK_SRC_RATE, 1'b1, '0);
    addStep(STOP_CLOCK, 1'b0, '0);
    addStep(SET_RESET, 1'b0, '0);
    addStep(RESET_PAR_REGS, 1'b1, '0);
    addStep(MBOX_DIS_PAR_CHK, 1'b1, '0);
    addStep(BURST_CTR_RH, 1'b1, '0);
    addStep(BURST_CTR_LH, 1'b1, '0);
    addStep(EBOX_CLK_DIS, 1'b1, '0);
    addStep(START_CLOCK, 1'b0, '0);
    addStep(INIT_CHANNELS, 1'b1, '0);
    addStep(BURST_CTR_RH, 1'b1, '0);
    // MBOX single steps until change coming clears
    repeat (steps) addStep(STEP_CLOCK, 1'b0, '0);
    // Phase two
    addStep(COND_STEP, 1'b0, '0);
    addStep(CLR_RESET, 1'b0, '0);
    addStep(ENABLE_KL, 1'b1, '0);
    addStep(EBUS_LOAD, 1'b1, '0);
    addStep(WRITE_MBOX, 1'b1, 36'o120);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic compareBus();
    busEntry_t exp;
    busEntry_t got;
    expectHex("bus cycle count", expQ.size(), seenQ.size());
    while (expQ.size() > 0) begin
      exp = expQ.pop_front();
      got = seenQ.pop_front();
      expectHex("ebus.ds", exp.ds, got.ds);
      expectHex("ebus.data", exp.data, got.data);
      expectHex("ebus.diagStrobe width", exp.strobeLen, got.strobeLen);
      expectHex("ebus.driving width", exp.driveLen, got.driveLen);
    end
  endtask

  // releaseAfter is the STEP_CLOCK count that clears change coming, -1 for never
  task automatic runCommand(input loadCmd_t c, input int releaseAfter,
                            input logic expSyncErr, input logic pokeWhileBusy);
    loadCmd_t other;
    seenQ.delete();
    stepBase       = stepClockSeen;
    aChangeComingN = (releaseAfter == 0);
    cmd            = c;
    cmdStart       = 1'b1;
    @(posedge clk);
    #1;
    cmdStart = 1'b0;
    if (pokeWhileBusy) begin
      repeat (3) @(posedge clk);
      #1;
      assert (busy) else failRun("Loader was not busy when the extra start arrived");
      other    = '0;
      other.op = masterReset;
      cmd      = other;
      cmdStart = 1'b1;
      @(posedge clk);
      #1;
      cmdStart = 1'b0;
    end
    do begin
      @(posedge clk);
      #1;
      if (releaseAfter >= 0 && stepClockSeen - stepBase >= releaseAfter) begin
        aChangeComingN = 1'b1;
      end
    end while (!done);
    expectHex("syncError", expSyncErr, syncError);
    @(posedge clk);
    #1;
    compareBus();
    if (pokeWhileBusy) begin
      // A dropped start must not run later
      repeat (25) @(posedge clk);
      #1;
      expectHex("busy", 0, busy);
      expectHex("bus cycles after done", 0, seenQ.size());
    end
  endtask

  initial begin
    loadCmd_t c;
    seed           = 2989;
    rstN           = 1'b0;
    cmdStart       = 1'b0;
    cmd            = '0;
    aChangeComingN = 1'b1;
    cramRun        = '0;
    dramRun        = '0;
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;
    expectHex("busy", 0, busy);
    expectHex("done", 0, done);
    expectHex("syncError", 0, syncError);
    expectHex("ebus.diagStrobe", 0, ebus.diagStrobe);
    expectHex("ebus.driving", 0, ebus.driving);

    // CRAM words, the middle one continues from the first
    c    = '0;
    c.op = cramWrite;
    for (int n = 0; n < 3; n++) begin
      c.adr = (n == 1) ? 11'd0 : (11'($random(seed)) | 11'd1);
      c.cw  = 86'({$random(seed), $random(seed), $random(seed)});
      buildCram(c);
      runCommand(c, 0, 1'b0, 1'b0);
    end

    // DRAM pairs in both IR forms, each followed by a continuation
    c    = '0;
    c.op = dramWrite;
    for (int n = 0; n < 4; n++) begin
      c.adr         = (n == 0) ? 11'o745 : (n == 2) ? 11'o236 : 11'd0;
      c.dram.even   = 16'($random(seed));
      c.dram.odd    = 16'($random(seed));
      c.dram.common = 16'($random(seed));
      buildDram(c);
      runCommand(c, 0, 1'b0, 1'b0);
    end

    // Soft reset with a start pulsed in the middle
    c    = '0;
    c.op = softReset;
    buildSoftReset();
    runCommand(c, 0, 1'b0, 1'b1);

    // Master resets that sync after 0, 2 and 4 steps
    c    = '0;
    c.op = masterReset;
    for (int k = 0; k <= 4; k += 2) begin
      buildMasterReset(k);
      runCommand(c, k, 1'b0, 1'b0);
    end
    // Never syncs, then a good one clears the error
    buildMasterReset(`FE_SYNC_MAX_STEPS);
    runCommand(c, -1, 1'b1, 1'b0);
    buildMasterReset(1);
    runCommand(c, 1, 1'b0, 1'b0);

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== feLoaderTop.f ====
+incdir+source
source/feLoaderPkg.sv
source/loadCmdRegs.sv
source/loadSequencer.sv
source/diagDataMux.sv
source/ebusCycle.sv
source/feLoaderTop.sv
dv/feLoaderTb.sv

// ==== source/diagDataMux.sv ====
// Diagnostic data formation
`include "feLoader_config.svh"

module diagDataMux (
  input  feLoaderPkg::diagStep_t  step,
  input  feLoaderPkg::loadCmd_t   curCmd,
  output feLoaderPkg::diagFunc_e  func,
  output logic                    isWrite,
  output logic [`FE_EBUS_W-1:0]   data
);
  import feLoaderPkg::*;

  logic [19:0]                  slice;
  logic [`FE_DRAM_FIELD_W-1:0]  dramWord;
  logic [`FE_DRAM_ADR_W-1:0]    dramAdr;
  logic [`FE_IR_W-1:0]          ir;

  assign func    = step.func;
  assign isWrite = step.isWrite;
  assign dramAdr = curCmd.adr[`FE_DRAM_ADR_W-1:0];

  // Twenty control bits starting at the slice's first KL control bit
  always_comb begin
    case (step.func)
      CRAM_WRITE_60_79: slice = curCmd.cw[`FE_CRAM_W-1-60 -: 20];
      CRAM_WRITE_40_59: slice = curCmd.cw[`FE_CRAM_W-1-40 -: 20];
      CRAM_WRITE_20_39: slice = curCmd.cw[`FE_CRAM_W-1-20 -: 20];
      default:          slice = curCmd.cw[`FE_CRAM_W-1 -: 20];
    endcase
  end

  // Even word for A/B and J8-10 even, odd word likewise, else common
  always_comb begin
    case (step.func)
      LDRAM1, LDRJEV: dramWord = curCmd.dram.even;
      LDRAM2, LDRJOD: dramWord = curCmd.dram.odd;
      default:        dramWord = curCmd.dram.common;
    endcase
  end

  // Opcode 7xx spreads the device and operation digits across IR
  always_comb begin
    if (dramAdr[8:6] != 3'o7) begin
      ir = {dramAdr, 4'b0000};
    end else begin
      ir = {dramAdr[8:6], 4'b0000, dramAdr[5:3], dramAdr[2:0]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // EBUS word, KL bit n at vector bit 35-n
  always_comb begin
    data = '0;
    case (step.slot)
      // CRAM address 5-10 into KL 0-5
      slotCramAdrRh: data[35:30] = curCmd.adr[5:0];
      // CRAM address 0-4 into KL 1-5
      slotCramAdrLh: data[34:30] = curCmd.adr[10:6];
      slotCramSlice: begin
        // Four-bit groups at KL 8, 14, 20, 26 and 32
        for (int g = 0; g < 5; g++) begin
          data[27 - 6*g -: 4] = slice[19 - 4*g -: 4];
        end
      end
      // CALL and DISP bits 80-85 into KL 0-5
      slotCram80:    data[35:30] = curCmd.cw[5:0];
      // IR into AR 0-12
      slotLoadAr:    data[35:23] = ir;
      slotDramWord:  data[33:18] = dramWord;
      slotMbox:      data = `FE_EBUS_W'(36'o120);
      default:       data = '0;
    endcase
  end

endmodule

// ==== source/ebusCycle.sv ====
// Diagnostic bus cycle timing
`include "feLoader_config.svh"

module ebusCycle (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   cycleReq,
  input  feLoaderPkg::diagFunc_e func,
  input  logic                   isWrite,
  input  logic [`FE_EBUS_W-1:0]  data,
  output feLoaderPkg::ebusDiag_t ebus,
  output logic                   cycleDone
);
  import feLoaderPkg::*;

  localparam int CntW = $clog2(`FE_FUNC_STROBE_CYC + 2);

  // Cycle number within the bus cycle, zero when idle
  logic [CntW-1:0]        cnt;
  logic [CntW-1:0]        lastCyc;
  logic [CntW-1:0]        strobeCyc;
  logic                   isWriteR;
  diagFunc_e              funcR;
  logic [`FE_EBUS_W-1:0]  dataR;

  // Done lands in the cycle after the longer of strobe and drive
  assign lastCyc   = isWriteR ? CntW'(`FE_WRITE_DRIVE_CYC + 1) :
                                CntW'(`FE_FUNC_STROBE_CYC + 1);
  assign strobeCyc = isWriteR ? CntW'(`FE_WRITE_STROBE_CYC) :
                                CntW'(`FE_FUNC_STROBE_CYC);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cnt      <= '0;
      isWriteR <= 1'b0;
      funcR    <= STOP_CLOCK;
    end else if (cycleReq) begin
      // A new request may land in the done cycle
      cnt      <= CntW'(1);
      isWriteR <= isWrite;
      funcR    <= func;
    end else if (cnt == lastCyc) begin
      cnt <= '0;
    end else if (cnt != '0) begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cycleReq) begin
      dataR <= data;
    end
  end

  always_comb begin
    // ds holds the last function between cycles
    ebus.ds         = funcR;
    ebus.diagStrobe = (cnt != '0) && (cnt <= strobeCyc);
    // Function cycles never drive
    ebus.driving    = isWriteR && (cnt != '0) && (cnt <= CntW'(`FE_WRITE_DRIVE_CYC));
    ebus.data       = ebus.driving ? dataR : '0;
    cycleDone       = (cnt == lastCyc);
  end

endmodule

// ==== source/feLoaderPkg.sv ====
// Front-end loader types
`include "feLoader_config.svh"

package feLoaderPkg;

  // Bit numbering follows the KL convention
  // KL bit n of a 36-bit word is vector bit 35-n
  // Control bit n of the CRAM word is vector bit 85-n

  // Diagnostic function codes, octal as in the KL docs
  typedef enum logic [6:0] {
    STOP_CLOCK       = 7'o000,
    START_CLOCK      = 7'o001,
    STEP_CLOCK       = 7'o002,
    COND_STEP        = 7'o004,
    CLR_RESET        = 7'o006,
    SET_RESET        = 7'o007,
    CLR_RUN          = 7'o010,
    IRLTCH           = 7'o014,
    // Clock board setup used by master reset
    BURST_CTR_RH     = 7'o042,
    BURST_CTR_LH     = 7'o043,
    CLK_SRC_RATE     = 7'o044,
    EBOX_CLK_DIS     = 7'o045,
    RESET_PAR_REGS   = 7'o046,
    MBOX_DIS_PAR_CHK = 7'o047,
    // CRAM diagnostic address and write slices
    CRAM_DIAG_ADR_RH = 7'o051,
    CRAM_DIAG_ADR_LH = 7'o052,
    CRAM_WRITE_80_85 = 7'o053,
    CRAM_WRITE_60_79 = 7'o054,
    CRAM_WRITE_40_59 = 7'o055,
    CRAM_WRITE_20_39 = 7'o056,
    CRAM_WRITE_00_19 = 7'o057,
    // DRAM loads
    LDRAM1           = 7'o060,
    LDRAM2           = 7'o061,
    LDRAM3           = 7'o062,
    LDRJEV           = 7'o063,
    LDRJOD           = 7'o064,
    ENABLE_KL        = 7'o067,
    INIT_CHANNELS    = 7'o070,
    WRITE_MBOX       = 7'o071,
    EBUS_LOAD        = 7'o076,
    LOAD_AR          = 7'o077
  } diagFunc_e;

  typedef enum logic [1:0] {
    cramWrite,
    dramWrite,
    softReset,
    masterReset
  } loadOp_e;

  // Which data word a write step puts on the EBUS
  typedef enum logic [2:0] {
    slotZero,
    slotCramAdrRh,
    slotCramAdrLh,
    slotCramSlice,
    slotCram80,
    slotLoadAr,
    slotDramWord,
    slotMbox
  } diagSlot_e;

  typedef struct packed {
    logic [`FE_DRAM_FIELD_W-1:0] even;
    logic [`FE_DRAM_FIELD_W-1:0] odd;
    logic [`FE_DRAM_FIELD_W-1:0] common;
  } dramPair_t;

  // valid marks a command in progress once latched
  typedef struct packed {
    logic                      valid;
    loadOp_e                   op;
    logic [`FE_CRAM_ADR_W-1:0] adr;
    logic [`FE_CRAM_W-1:0]     cw;
    dramPair_t                 dram;
  } loadCmd_t;

  typedef struct packed {
    diagFunc_e func;
    logic      isWrite;
    diagSlot_e slot;
  } diagStep_t;

  typedef struct packed {
    logic [6:0]            ds;
    logic                  diagStrobe;
    logic                  driving;
    logic [`FE_EBUS_W-1:0] data;
  } ebusDiag_t;

endpackage

// ==== source/feLoaderTop.sv ====
// Front-end diagnostic loader
`include "feLoader_config.svh"

module feLoaderTop (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   cmdStart,
  input  feLoaderPkg::loadCmd_t  cmd,
  input  logic                   aChangeComingN,
  output feLoaderPkg::ebusDiag_t ebus,
  output logic                   busy,
  output logic                   done,
  output logic                   syncError
);
  import feLoaderPkg::*;

  loadCmd_t               curCmd;
  logic                   go;
  diagStep_t              step;
  logic                   cycleReq;
  logic                   cycleDone;
  diagFunc_e              func;
  logic                   isWrite;
  logic [`FE_EBUS_W-1:0]  data;

  // Command latch, busy and running addresses
  loadCmdRegs uCmdRegs (
    .clk      (clk),
    .rstN     (rstN),
    .cmdStart (cmdStart),
    .cmd      (cmd),
    .seqDone  (done),
    .go       (go),
    .curCmd   (curCmd),
    .busy     (busy)
  );

  // Walks the step list, done pulses after the last step
  loadSequencer uSeq (
    .clk            (clk),
    .rstN           (rstN),
    .go             (go),
    .op             (curCmd.op),
    .aChangeComingN (aChangeComingN),
    .cycleDone      (cycleDone),
    .step           (step),
    .cycleReq       (cycleReq),
    .seqDone        (done),
    .syncError      (syncError)
  );

  diagDataMux uMux (
    .step    (step),
    .curCmd  (curCmd),
    .func    (func),
    .isWrite (isWrite),
    .data    (data)
  );

  // Strobe and drive timing on the EBUS
  ebusCycle uCycle (
    .clk       (clk),
    .rstN      (rstN),
    .cycleReq  (cycleReq),
    .func      (func),
    .isWrite   (isWrite),
    .data      (data),
    .ebus      (ebus),
    .cycleDone (cycleDone)
  );

endmodule

// ==== source/feLoader_config.svh ====
// Front-end loader configuration
`ifndef FELOADER_CONFIG_SVH
`define FELOADER_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Widths

// EBUS data path
`define FE_EBUS_W 36
// Control word is 80 bits plus the 6-bit CALL/DISP special field
`define FE_CRAM_W 86
`define FE_CRAM_ADR_W 11
`define FE_DRAM_ADR_W 9
// Even, odd and common DRAM words
`define FE_DRAM_FIELD_W 16
// IR value that addresses the DRAM
`define FE_IR_W 13

////////////////////////////////////////////////////////////////////////////
// Bus cycle timing, in clocks

`define FE_WRITE_STROBE_CYC 3
`define FE_WRITE_DRIVE_CYC 4
`define FE_FUNC_STROBE_CYC 18

////////////////////////////////////////////////////////////////////////////
// Master-reset MBOX sync loop

// Wait before each change-coming sample
`define FE_SYNC_WAIT_CYC 5
`define FE_SYNC_MAX_STEPS 5

`endif

// ==== source/loadCmdRegs.sv ====
// Command latch and running addresses
`include "feLoader_config.svh"

module loadCmdRegs (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  cmdStart,
  input  feLoaderPkg::loadCmd_t cmd,
  input  logic                  seqDone,
  output logic                  go,
  output feLoaderPkg::loadCmd_t curCmd,
  output logic                  busy
);
  import feLoaderPkg::*;

  logic                      accept;
  logic [`FE_CRAM_ADR_W-1:0] cramAdr;
  logic [`FE_DRAM_ADR_W-1:0] dramAdr;
  logic [`FE_DRAM_ADR_W-1:0] dramReq;
  loadCmd_t                  nextCmd;
  loadCmd_t                  cmdR;

  // Starts during a command are dropped
  assign accept  = cmdStart && !busy;
  assign dramReq = cmd.adr[`FE_DRAM_ADR_W-1:0];

  // Address zero continues after the previous record
  always_comb begin
    nextCmd = cmd;
    if (cmd.op == cramWrite && cmd.adr == '0) begin
      nextCmd.adr = cramAdr;
    end
    if (cmd.op == dramWrite) begin
      nextCmd.adr = `FE_CRAM_ADR_W'((dramReq == '0) ? dramAdr : dramReq);
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      busy    <= 1'b0;
      go      <= 1'b0;
      cramAdr <= '0;
      dramAdr <= '0;
    end else begin
      go <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (seqDone && busy) begin
        busy <= 1'b0;
        // One CRAM word, or an even/odd DRAM pair
        if (cmdR.op == cramWrite) begin
          cramAdr <= cmdR.adr + 1'b1;
        end
        if (cmdR.op == dramWrite) begin
          dramAdr <= cmdR.adr[`FE_DRAM_ADR_W-1:0] + `FE_DRAM_ADR_W'(2);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmdR <= nextCmd;
    end
  end

  always_comb begin
    curCmd       = cmdR;
    curCmd.valid = busy;
  end

endmodule

// ==== source/loadSequencer.sv ====
// Diagnostic step sequencer
`include "feLoader_config.svh"

module loadSequencer (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   go,
  input  feLoaderPkg::loadOp_e   op,
  input  logic                   aChangeComingN,
  input  logic                   cycleDone,
  output feLoaderPkg::diagStep_t step,
  output logic                   cycleReq,
  output logic                   seqDone,
  output logic                   syncError
);
  import feLoaderPkg::*;

  localparam int WaitW = $clog2(`FE_SYNC_WAIT_CYC);
  localparam int SyncW = $clog2(`FE_SYNC_MAX_STEPS + 1);
  // Master-reset slot of the looped STEP_CLOCK, between phase one and two
  localparam logic [4:0] SyncIdx = 5'd12;

  typedef enum logic [2:0] {
    idle,
    issue,
    waitCycle,
    syncWait,
    finish
  } seqState_e;

  seqState_e        state;
  logic [4:0]       stepCnt;
  logic [WaitW-1:0] waitCnt;
  logic [SyncW-1:0] syncCnt;
  logic             atSync;
  logic             listEnd;
  logic             chainReq;

  function automatic diagStep_t fnStep(diagFunc_e f);
    return '{f, 1'b0, slotZero};
  endfunction

  function automatic diagStep_t wrStep(diagFunc_e f, diagSlot_e s);
    return '{f, 1'b1, s};
  endfunction

  function automatic logic [4:0] lastIdx(loadOp_e o);
    case (o)
      softReset:   return 5'd4;
      masterReset: return 5'd17;
      default:     return 5'd6;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Step lists, one per command
  function automatic diagStep_t stepAt(loadOp_e o, logic [4:0] i);
    case (o)
      cramWrite:
        case (i)
          5'd0:    return wrStep(CRAM_DIAG_ADR_RH, slotCramAdrRh);
          5'd1:    return wrStep(CRAM_DIAG_ADR_LH, slotCramAdrLh);
          5'd2:    return wrStep(CRAM_WRITE_60_79, slotCramSlice);
          5'd3:    return wrStep(CRAM_WRITE_40_59, slotCramSlice);
          5'd4:    return wrStep(CRAM_WRITE_20_39, slotCramSlice);
          5'd5:    return wrStep(CRAM_WRITE_00_19, slotCramSlice);
          default: return wrStep(CRAM_WRITE_80_85, slotCram80);
        endcase
      dramWrite:
        case (i)
          // IR gets the DRAM address through AR
          5'd0:    return wrStep(LOAD_AR, slotLoadAr);
          5'd1:    return fnStep(IRLTCH);
          5'd2:    return wrStep(LDRAM1, slotDramWord);
          5'd3:    return wrStep(LDRAM2, slotDramWord);
          5'd4:    return wrStep(LDRAM3, slotDramWord);
          5'd5:    return wrStep(LDRJEV, slotDramWord);
          default: return wrStep(LDRJOD, slotDramWord);
        endcase
      softReset:
        case (i)
          5'd0:    return fnStep(SET_RESET);
          5'd1:    return fnStep(START_CLOCK);
          5'd2:    return fnStep(STOP_CLOCK);
          5'd3:    return fnStep(COND_STEP);
          default: return fnStep(CLR_RESET);
        endcase
      default:
        case (i)
          5'd0:    return fnStep(CLR_RUN);
          // Phase one
          5'd1:    return wrStep(CLK_SRC_RATE, slotZero);
          5'd2:    return fnStep(STOP_CLOCK);
          5'd3:    return fnStep(SET_RESET);
          5'd4:    return wrStep(RESET_PAR_REGS, slotZero);
          5'd5:    return wrStep(MBOX_DIS_PAR_CHK, slotZero);
          5'd6:    return wrStep(BURST_CTR_RH, slotZero);
          5'd7:    return wrStep(BURST_CTR_LH, slotZero);
          5'd8:    return wrStep(EBOX_CLK_DIS, slotZero);
          5'd9:    return fnStep(START_CLOCK);
          5'd10:   return wrStep(INIT_CHANNELS, slotZero);
          5'd11:   return wrStep(BURST_CTR_RH, slotZero);
          // Single step of the MBOX sync loop
          5'd12:   return fnStep(STEP_CLOCK);
          // Phase two
          5'd13:   return fnStep(COND_STEP);
          5'd14:   return fnStep(CLR_RESET);
          5'd15:   return wrStep(ENABLE_KL, slotZero);
          5'd16:   return wrStep(EBUS_LOAD, slotZero);
          default: return wrStep(WRITE_MBOX, slotMbox);
        endcase
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Step issue
  always_comb begin
    atSync  = (op == masterReset) && (stepCnt == SyncIdx);
    listEnd = stepCnt > lastIdx(op);
    // Next step goes out in the done cycle, leaving one idle bus cycle
    chainReq = (state == waitCycle) && cycleDone && !atSync && !listEnd;
    cycleReq = (state == issue) || chainReq;
    seqDone  = (state == finish);
    step     = stepAt(op, stepCnt);
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= idle;
      stepCnt   <= '0;
      waitCnt   <= '0;
      syncCnt   <= '0;
      syncError <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (go) begin
            stepCnt <= '0;
            syncCnt <= '0;
            state   <= issue;
            if (op == masterReset) begin
              syncError <= 1'b0;
            end
          end
        end
        issue: begin
          // Loop steps reuse the STEP_CLOCK slot
          if (!atSync) begin
            stepCnt <= stepCnt + 5'd1;
          end
          state <= waitCycle;
        end
        waitCycle: begin
          if (cycleDone) begin
            if (atSync) begin
              waitCnt <= '0;
              state   <= syncWait;
            end else if (listEnd) begin
              state <= finish;
            end else begin
              stepCnt <= stepCnt + 5'd1;
            end
          end
        end
        syncWait: begin
          waitCnt <= waitCnt + 1'b1;
          if (waitCnt == WaitW'(`FE_SYNC_WAIT_CYC - 1)) begin
            state <= issue;
            // Change coming still set, step the MBOX again
            if (!aChangeComingN && syncCnt != SyncW'(`FE_SYNC_MAX_STEPS)) begin
              syncCnt <= syncCnt + 1'b1;
            end else begin
              stepCnt <= SyncIdx + 5'd1;
              if (!aChangeComingN) begin
                syncError <= 1'b1;
              end
            end
          end
        end
        finish: begin
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

endmodule
